// ==== common/can_status_pkg.sv ====
// counters wrap silently; thresholds follow the CAN fault confinement rules without the REC reload to 127
package can_status_pkg;

  localparam int err_count_w   = 8;
  localparam int frame_count_w = 16;

  localparam int passive_limit      = 127;
  localparam int warning_limit      = 96;
  localparam int recovery_sequences = 128;
  localparam int tx_error_step      = 8;
  localparam int recovery_count_w   = $clog2(recovery_sequences);

  typedef enum logic [1:0] {
    error_active  = 2'd0,
    error_passive = 2'd1,
    bus_off       = 2'd2
  } node_state_e;

  typedef logic [err_count_w-1:0]      err_count_t;
  typedef logic [frame_count_w-1:0]    frame_count_t;
  typedef logic [recovery_count_w-1:0] recovery_count_t;

  typedef struct packed {
    node_state_e  node_state;
    frame_count_t frames_sent;
    frame_count_t frames_received;
    frame_count_t errors_detected;
    err_count_t   tec;
    err_count_t   rec;
    logic         bus_off;
  } can_status_t;

  // bus-off wins over error passive
  function automatic node_state_e node_state_of(err_count_t tec, err_count_t rec, logic off);
    if (off) return bus_off;
    if (tec > passive_limit || rec > passive_limit) return error_passive;
    return error_active;
  endfunction

endpackage

// ==== common/can_log_pkg.sv ====
// records carry a snapshot of TEC/REC only; warn_is_tx has no meaning in monitor records
package can_log_pkg;

  import can_status_pkg::*;

  localparam int log_depth   = 16;
  localparam int log_index_w = $clog2(log_depth);

  typedef logic [log_index_w-1:0] log_index_t;

  typedef enum logic {
    src_monitor     = 1'b0,
    src_confinement = 1'b1
  } log_source_e;

  typedef struct packed {
    log_source_e source;
    node_state_e node_state;
    err_count_t  tec;
    err_count_t  rec;
    logic        warn_is_tx;
  } log_record_t;

  // overflow is sticky and rides along with every pop
  typedef struct packed {
    logic        valid;
    logic        overflow;
    log_record_t record;
  } log_pop_t;

endpackage

// ==== fault_confinement/can_fault_confinement.sv ====
// strobes must be single-cycle; error and ok strobes are ignored in bus-off, recessive_11 only counts there
`timescale 1ns/1ps
module can_fault_confinement
  import can_status_pkg::*, can_log_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        tx_error,
  input  logic        rx_error,
  input  logic        tx_ok,
  input  logic        rx_ok,
  input  logic        recessive_11,
  output err_count_t  tec,
  output err_count_t  rec,
  output logic        bus_off,
  output logic        warn_req,
  output log_record_t warn_record
);

  // one spare bit to catch the step past 255
  logic [err_count_w:0] tec_sum;
  logic [err_count_w:0] rec_sum;
  err_count_t           tec_next;
  err_count_t           rec_next;
  logic                 enter_bus_off;
  recovery_count_t      recovery_count;
  logic                 recovery_done;
  logic                 tx_cross_q;
  logic                 rx_cross_q;
  logic                 rx_queued;

  always_comb begin
    tec_sum = {1'b0, tec};
    if (tx_error) tec_sum = tec_sum + (err_count_w+1)'(tx_error_step);
    if (tx_ok && tec_sum != '0) tec_sum = tec_sum - 1'b1;

    rec_sum = {1'b0, rec};
    if (rx_error) rec_sum = rec_sum + 1'b1;
    if (rx_ok && rec_sum != '0) rec_sum = rec_sum - 1'b1;

    enter_bus_off = tec_sum[err_count_w];
    tec_next = enter_bus_off ? '1 : tec_sum[err_count_w-1:0];
    rec_next = rec_sum[err_count_w] ? '1 : rec_sum[err_count_w-1:0];
  end

  assign recovery_done = bus_off && recessive_11 &&
                         recovery_count == recovery_count_t'(recovery_sequences - 1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tec            <= '0;
      rec            <= '0;
      bus_off        <= 1'b0;
      recovery_count <= '0;
    end else if (bus_off) begin
      if (recovery_done) begin
        tec            <= '0;
        rec            <= '0;
        bus_off        <= 1'b0;
        recovery_count <= '0;
      end else if (recessive_11) begin
        recovery_count <= recovery_count + 1'b1;
      end
    end else begin
      tec     <= tec_next;
      rec     <= rec_next;
      bus_off <= enter_bus_off;
    end
  end

  // upward crossings of the warning level, flagged with the new value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_cross_q <= 1'b0;
      rx_cross_q <= 1'b0;
      rx_queued  <= 1'b0;
    end else begin
      tx_cross_q <= !bus_off && tec < warning_limit && tec_next >= warning_limit;
      rx_cross_q <= !bus_off && rec < warning_limit && rec_next >= warning_limit;
      // REC record goes out one cycle behind a simultaneous TEC record
      rx_queued  <= tx_cross_q && rx_cross_q;
    end
  end

  assign warn_req = tx_cross_q | rx_cross_q | rx_queued;

  always_comb begin
    warn_record.source     = src_confinement;
    warn_record.node_state = node_state_of(tec, rec, bus_off);
    warn_record.tec        = tec;
    warn_record.rec        = rec;
    warn_record.warn_is_tx = tx_cross_q;
  end

endmodule

// ==== source/can_status_monitor.sv ====
// tx_active/rx_active are levels sampled each cycle; any_error counts at most once per cycle
`timescale 1ns/1ps
module can_status_monitor
  import can_status_pkg::*, can_log_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        tx_active,
  input  logic        rx_active,
  input  logic        any_error,
  input  err_count_t  tec,
  input  err_count_t  rec,
  input  logic        bus_off,
  output can_status_t status,
  output logic        state_req,
  output log_record_t state_record
);

  logic         tx_active_q;
  logic         rx_active_q;
  frame_count_t frames_sent;
  frame_count_t frames_received;
  frame_count_t errors_detected;
  node_state_e  node_state;
  node_state_e  state_prev;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_active_q     <= 1'b0;
      rx_active_q     <= 1'b0;
      frames_sent     <= '0;
      frames_received <= '0;
      errors_detected <= '0;
      node_state      <= error_active;
      state_prev      <= error_active;
      state_req       <= 1'b0;
    end else begin
      tx_active_q <= tx_active;
      rx_active_q <= rx_active;

      // rising edges only
      if (tx_active && !tx_active_q) frames_sent <= frames_sent + 1'b1;
      if (rx_active && !rx_active_q) frames_received <= frames_received + 1'b1;
      if (any_error) errors_detected <= errors_detected + 1'b1;

      node_state <= node_state_of(tec, rec, bus_off);
      state_prev <= node_state;
      // strobe lands the cycle after the new state shows
      state_req  <= node_state != state_prev;
    end
  end

  always_comb begin
    status.node_state      = node_state;
    status.frames_sent     = frames_sent;
    status.frames_received = frames_received;
    status.errors_detected = errors_detected;
    status.tec             = tec;
    status.rec             = rec;
    status.bus_off         = bus_off;
  end

  always_comb begin
    state_record.source     = src_monitor;
    state_record.node_state = node_state;
    state_record.tec        = tec;
    state_record.rec        = rec;
    state_record.warn_is_tx = 1'b0;
  end

endmodule

// ==== source/can_log_arbiter.sv ====
// one strobe per input per slot drain; a strobe into a still-full slot replaces the held record
`timescale 1ns/1ps
module can_log_arbiter #(
  parameter type record_t = logic [7:0]
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic [1:0]    req,
  input  record_t [1:0] records,
  output logic          wr,
  output record_t       wr_record
);

  logic [1:0]    pending_valid;
  record_t [1:0] pending_record;
  // input that wins when both slots are full
  logic          priority_idx;
  logic          grant_idx;
  logic [1:0]    grant;

  always_comb begin
    if (pending_valid[0] && pending_valid[1]) begin
      grant_idx = priority_idx;
    end else begin
      grant_idx = pending_valid[1];
    end
    grant            = '0;
    grant[grant_idx] = |pending_valid;
  end

  assign wr        = |pending_valid;
  assign wr_record = pending_record[grant_idx];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pending_valid <= '0;
      priority_idx  <= 1'b0;
    end else begin
      // a new strobe refills a slot in the cycle it drains
      pending_valid <= (pending_valid & ~grant) | req;
      // priority passes to the input not just served
      if (wr) priority_idx <= ~grant_idx;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (req[i]) pending_record[i] <= records[i];
    end
  end

endmodule

// ==== source/can_event_log.sv ====
// full log drops the incoming record even when a pop frees a slot in the same cycle
`timescale 1ns/1ps
module can_event_log
  import can_log_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        wr,
  input  log_record_t wr_record,
  input  logic        pop,
  output log_pop_t    pop_result
);

  log_record_t                 mem [log_depth];
  log_index_t                  head;
  log_index_t                  tail;
  logic [$bits(log_index_t):0] fill_count;
  logic                        full;
  logic                        wr_ok;
  logic                        pop_ok;
  logic                        overflow;
  logic                        pop_valid;
  log_record_t                 pop_record;

  assign full   = fill_count == log_depth;
  assign wr_ok  = wr && !full;
  assign pop_ok = pop && fill_count != '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head       <= '0;
      tail       <= '0;
      fill_count <= '0;
      overflow   <= 1'b0;
      pop_valid  <= 1'b0;
    end else begin
      // pointers wrap with the index width
      if (wr_ok) tail <= tail + 1'b1;
      if (pop_ok) head <= head + 1'b1;
      case ({wr_ok, pop_ok})
        2'b10:   fill_count <= fill_count + 1'b1;
        2'b01:   fill_count <= fill_count - 1'b1;
        default: ;
      endcase
      if (wr && full) overflow <= 1'b1;
      pop_valid <= pop_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ok) mem[tail] <= wr_record;
    if (pop_ok) pop_record <= mem[head];
  end

  always_comb begin
    pop_result.valid    = pop_valid;
    pop_result.overflow = overflow;
    pop_result.record   = pop_record;
  end

endmodule

// ==== source/can_status_top.sv ====
// all inputs are per-cycle strobes or levels; the host sees the log only through the pop strobe
`timescale 1ns/1ps
module can_status_top
  import can_status_pkg::*, can_log_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        tx_active,
  input  logic        rx_active,
  input  logic        tx_error,
  input  logic        rx_error,
  input  logic        tx_ok,
  input  logic        rx_ok,
  input  logic        recessive_11,
  input  logic        pop,
  output can_status_t status,
  output log_pop_t    pop_result
);

  err_count_t  tec;
  err_count_t  rec;
  logic        fc_bus_off;
  logic        warn_req;
  log_record_t warn_record;
  logic        state_req;
  log_record_t state_record;
  logic        any_error;
  logic        log_wr;
  log_record_t log_wr_record;

  assign any_error = tx_error | rx_error;

  can_fault_confinement u_fault_confinement (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx_error    (tx_error),
    .rx_error    (rx_error),
    .tx_ok       (tx_ok),
    .rx_ok       (rx_ok),
    .recessive_11(recessive_11),
    .tec         (tec),
    .rec         (rec),
    .bus_off     (fc_bus_off),
    .warn_req    (warn_req),
    .warn_record (warn_record)
  );

  can_status_monitor u_monitor (
    .clk         (clk),
    .rst_n       (rst_n),
    .tx_active   (tx_active),
    .rx_active   (rx_active),
    .any_error   (any_error),
    .tec         (tec),
    .rec         (rec),
    .bus_off     (fc_bus_off),
    .status      (status),
    .state_req   (state_req),
    .state_record(state_record)
  );

  // input 0 is the monitor, input 1 the fault confinement unit
  can_log_arbiter #(
    .record_t(log_record_t)
  ) u_arbiter (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      ({warn_req, state_req}),
    .records  ({warn_record, state_record}),
    .wr       (log_wr),
    .wr_record(log_wr_record)
  );

  can_event_log u_event_log (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr        (log_wr),
    .wr_record (log_wr_record),
    .pop       (pop),
    .pop_result(pop_result)
  );

endmodule

// ==== tb/tb_clock_gen.sv ====
// free-running 10 ns clock; reset low for the first 3 cycles, released on a falling edge
`timescale 1ns/1ps
module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// ==== tb/can_status_assertions.sv ====
// one checker bound to both the arbiter and the log; unused ports are tied off in each bind
`timescale 1ns/1ps
module can_status_assertions (
  input logic       clk,
  input logic       rst_n,
  input logic       wr,
  input logic [1:0] req,
  input logic [1:0] pending_valid,
  input logic       pop,
  input logic       pop_valid,
  input logic [4:0] fill_count
);

  // back-to-back writes need a fresh strobe or two held records
  assert property (@(posedge clk) disable iff (!rst_n)
    wr && $past(wr) |-> $past(|req) || $past(&pending_valid))
    else $error("arbiter wrote twice in a row without a pending record");

  assert property (@(posedge clk) disable iff (!rst_n) $rose(pop_valid) |-> $past(pop))
    else $error("pop result became valid without a pop");

  assert property (@(posedge clk) disable iff (!rst_n) fill_count <= 5'd16)
    else $error("log fill count above depth");

endmodule

bind can_log_arbiter can_status_assertions u_arbiter_checks (
  .clk(clk), .rst_n(rst_n), .wr(wr), .req(req), .pending_valid(pending_valid),
  .pop(1'b1), .pop_valid(1'b0), .fill_count(5'd0)
);

bind can_event_log can_status_assertions u_log_checks (
  .clk(clk), .rst_n(rst_n), .wr(1'b0), .req(2'b00), .pending_valid(2'b11),
  .pop(pop), .pop_valid(pop_valid), .fill_count(fill_count)
);

// ==== tb/can_status_tb.sv ====
// trace lines repeat a strobe pattern; the model assumes the trace never overruns an arbiter slot
`timescale 1ns/1ps
module can_status_tb
  import can_status_pkg::*, can_log_pkg::*;
();

  logic        clk;
  logic        rst_n;
  logic        tx_active, rx_active, tx_error, rx_error;
  logic        tx_ok, rx_ok, recessive_11, pop;
  can_status_t status;
  log_pop_t    pop_result;

  logic [43:0] trace [0:63];
  int          total_cycles;
  int          error_count;

  // reference model state
  err_count_t   m_tec, m_rec;
  logic         m_boff, m_txq, m_rxq, m_rxqd, m_sreq;
  int           m_rcnt;
  logic         m_tx_q, m_rx_q;
  frame_count_t m_sent, m_recv, m_errs;
  node_state_e  m_state, m_state_prev;
  logic [1:0]   m_pend_v;
  log_record_t  m_pend_r [2];
  int           m_prio;
  log_record_t  m_log [$];
  logic         m_overflow, m_pop_valid;
  log_record_t  m_pop_rec;

  tb_clock_gen u_clock (.clk(clk), .rst_n(rst_n));

  can_status_top UUT (
    .clk(clk), .rst_n(rst_n), .tx_active(tx_active), .rx_active(rx_active),
    .tx_error(tx_error), .rx_error(rx_error), .tx_ok(tx_ok), .rx_ok(rx_ok),
    .recessive_11(recessive_11), .pop(pop), .status(status), .pop_result(pop_result)
  );

  function automatic node_state_e classify_state(input int t, input int r, input logic off);
    if (off) return bus_off;
    if (t > 127 || r > 127) return error_passive;
    return error_active;
  endfunction

  // digit 1 every cycle, 2 even cycles, 3 odd cycles of the line
  function automatic logic strobe_on(input logic [3:0] d, input int c);
    return d == 4'd1 || (d == 4'd2 && c % 2 == 0) || (d == 4'd3 && c % 2 == 1);
  endfunction

  task automatic stop_with_failure();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("Fail at %0t ns: %s", $time, what);
    stop_with_failure();
  endtask

  task automatic model_step();
    int          t;
    int          r;
    int          g;
    logic        wreq;
    logic        do_wr;
    logic        full;
    log_record_t srec;
    log_record_t wrec;
    log_record_t grant_rec;
    srec = '{src_monitor, m_state, m_tec, m_rec, 1'b0};
    wrec = '{src_confinement, classify_state(m_tec, m_rec, m_boff), m_tec, m_rec, m_txq};
    wreq = m_txq | m_rxq | m_rxqd;
    // round-robin over the held records
    do_wr = |m_pend_v;
    if (&m_pend_v) g = m_prio;
    else g = m_pend_v[1] ? 1 : 0;
    grant_rec = m_pend_r[g];
    if (do_wr) begin
      m_pend_v[g] = 1'b0;
      m_prio = 1 - g;
    end
    if (m_sreq) begin
      m_pend_v[0] = 1'b1;
      m_pend_r[0] = srec;
    end
    if (wreq) begin
      m_pend_v[1] = 1'b1;
      m_pend_r[1] = wrec;
    end
    full = m_log.size() == log_depth;
    m_pop_valid = pop && m_log.size() != 0;
    if (m_pop_valid) m_pop_rec = m_log.pop_front();
    if (do_wr && full) m_overflow = 1'b1;
    else if (do_wr) m_log.push_back(grant_rec);
    // monitor
    if (tx_active && !m_tx_q) m_sent = m_sent + 1'b1;
    if (rx_active && !m_rx_q) m_recv = m_recv + 1'b1;
    if (tx_error || rx_error) m_errs = m_errs + 1'b1;
    m_tx_q = tx_active;
    m_rx_q = rx_active;
    m_sreq = m_state != m_state_prev;
    m_state_prev = m_state;
    m_state = classify_state(m_tec, m_rec, m_boff);
    // fault confinement
    m_rxqd = m_txq && m_rxq;
    t = m_tec;
    r = m_rec;
    if (!m_boff) begin
      if (tx_error) t += 8;
      if (tx_ok && t > 0) t--;
      if (rx_error) r++;
      if (rx_ok && r > 0) r--;
      m_txq = m_tec < 96 && t >= 96;
      m_rxq = m_rec < 96 && r >= 96;
      if (t > 255) begin
        m_boff = 1'b1;
        t = 255;
      end
      if (r > 255) r = 255;
      m_tec = err_count_t'(t);
      m_rec = err_count_t'(r);
    end else begin
      m_txq = 1'b0;
      m_rxq = 1'b0;
      if (recessive_11 && m_rcnt == 127) begin
        m_tec = '0;
        m_rec = '0;
        m_boff = 1'b0;
        m_rcnt = 0;
      end else if (recessive_11) begin
        m_rcnt++;
      end
    end
  endtask

  always @(posedge clk) begin
    if (rst_n) model_step();
  end

  task automatic compare_outputs();
    can_status_t want;
    want = '{m_state, m_sent, m_recv, m_errs, m_tec, m_rec, m_boff};
    assert (status == want)
      else report_error($sformatf("status %h, expected %h", status, want));
    assert (pop_result.valid == m_pop_valid && pop_result.overflow == m_overflow)
      else report_error($sformatf("pop valid/overflow %b%b, expected %b%b",
                                  pop_result.valid, pop_result.overflow, m_pop_valid, m_overflow));
    if (m_pop_valid) begin
      assert (pop_result.record == m_pop_rec)
        else report_error($sformatf("popped %h, expected %h", pop_result.record, m_pop_rec));
    end
  endtask

  task automatic check_state(input logic [3:0] exp);
    if (exp != 4'd3) begin
      assert (status.node_state == node_state_e'(exp[1:0]))
        else report_error($sformatf("node state %0d, trace expects %0d", status.node_state, exp));
    end
  endtask

  task automatic drive_cycle(input logic [43:0] line, input int c);
    tx_active    = strobe_on(line[35:32], c);
    rx_active    = strobe_on(line[31:28], c);
    tx_error     = strobe_on(line[27:24], c);
    rx_error     = strobe_on(line[23:20], c);
    tx_ok        = strobe_on(line[19:16], c);
    rx_ok        = strobe_on(line[15:12], c);
    recessive_11 = strobe_on(line[11:8], c);
    pop          = strobe_on(line[7:4], c);
  endtask

  initial begin
    int n_lines;
    {tx_active, rx_active, tx_error, rx_error, tx_ok, rx_ok, recessive_11, pop} = '0;
    {m_tec, m_rec, m_boff, m_txq, m_rxq, m_rxqd, m_sreq, m_tx_q, m_rx_q} = '0;
    {m_sent, m_recv, m_errs, m_pend_v, m_overflow, m_pop_valid} = '0;
    m_state = error_active;
    m_state_prev = error_active;
    m_rcnt = 0;
    m_prio = 0;
    error_count = 0;
    total_cycles = 0;
    for (int i = 0; i < 64; i++) trace[i] = '0;
    $readmemh("tb/can_status_trace.txt", trace);
    n_lines = 0;
    while (n_lines < 64 && trace[n_lines][43:36] != 8'd0) begin
      total_cycles += int'(trace[n_lines][43:36]);
      n_lines++;
    end
    wait (rst_n);
    for (int li = 0; li < n_lines; li++) begin
      for (int c = 0; c < int'(trace[li][43:36]); c++) begin
        @(negedge clk);
        compare_outputs();
        if (c == 0 && li > 0) check_state(trace[li-1][3:0]);
        drive_cycle(trace[li], c);
      end
    end
    @(negedge clk);
    compare_outputs();
    check_state(trace[n_lines-1][3:0]);
    drive_cycle('0, 0);
    repeat (5) begin
      @(negedge clk);
      compare_outputs();
    end
    if (error_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      stop_with_failure();
    end
  end

  initial begin
    wait (total_cycles > 0);
    #((total_cycles + 20) * 10);
    $display("watchdog expired before the trace finished");
    stop_with_failure();
  end

endmodule

// ==== tb/can_status_trace.txt ====
// repeat(hex) _ tx_active rx_active tx_error rx_error tx_ok rx_ok recessive_11 pop _ state
// flag 0 off, 1 every cycle, 2 even cycles, 3 odd cycles; state 3 is not checked
04_00000000_0
03_10000000_0
02_01000000_0
02_11000000_0
01_00000000_0
01_00110000_0
01_00101000_0
01_00111100_0
02_00001100_0
5F_00010000_3
0A_00100000_3
01_00110000_3
04_00000000_0
20_00010000_3
03_00000000_1
04_00000001_1
20_00100000_3
03_00000000_2
02_00111100_2
80_00000010_3
03_00000000_0
5F_00010000_3
28_00020300_0
16_00000001_0

// ==== all.f ====
common/can_status_pkg.sv
common/can_log_pkg.sv
fault_confinement/can_fault_confinement.sv
source/can_status_monitor.sv
source/can_log_arbiter.sv
source/can_event_log.sv
source/can_status_top.sv
tb/tb_clock_gen.sv
tb/can_status_assertions.sv
tb/can_status_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module can_status_tb \
  -f all.f -o sim_can_status \
  && ./obj_dir/sim_can_status | tee /dev/stderr | grep -qx "PASS: all tests" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
